// File: design/cpu_pkg.sv
package cpu_pkg;

  localparam int data_w     = 16;  // data and instruction word
  localparam int addr_w     = 8;   // both memories
  localparam int reg_addr_w = 3;
  localparam int num_regs   = 2 ** reg_addr_w;
  localparam int op_w       = 4;
  localparam int alu_op_w   = 4;
  localparam int mem_op_w   = 2;

  localparam int imem_depth = 256;
  localparam int dmem_depth = 256;

  // instruction fields, lsb positions
  localparam int op_lsb = 12;
  localparam int rs_lsb = 9;
  localparam int rt_lsb = 6;
  localparam int rd_lsb = 3;
  localparam int imm_w  = 6;  // imm6 sits at bit 0

  typedef enum logic [op_w-1:0] {
    op_add, op_addi, op_sub, op_subi,
    op_not, op_and, op_or, op_nand,
    op_nor, op_mov, op_li, op_lw,
    op_sw, op_beq, op_bne, op_jump
  } opcode_t;

  typedef enum logic [alu_op_w-1:0] {
    alu_add, alu_sub, alu_not, alu_and, alu_or,
    alu_nand, alu_nor, alu_pass_a, alu_pass_b
  } alu_op_t;

  typedef enum logic [mem_op_w-1:0] {
    mem_none,
    mem_read,
    mem_write
  } mem_op_t;

  // sign extended imm6 of an instruction word
  function automatic logic [data_w-1:0] imm_ext(input logic [data_w-1:0] word);
    return {{(data_w - imm_w){word[imm_w-1]}}, word[imm_w-1:0]};
  endfunction

endpackage

// File: design/ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if;
  import cpu_pkg::*;

  logic    reg_dst;      // 1: write rd, 0: write rt
  logic    alu_src;      // 1: immediate as operand b
  logic    mem_to_reg;   // load word to register file
  logic    reg_write;
  mem_op_t mem_op;
  alu_op_t alu_op;
  logic    beq;
  logic    bne;
  logic    address_src;  // jump

  modport decoder (
    output reg_dst, alu_src, mem_to_reg, reg_write, mem_op, alu_op,
           beq, bne, address_src
  );

  modport sink (
    input reg_dst, alu_src, mem_to_reg, reg_write, mem_op, alu_op,
          beq, bne, address_src
  );

endinterface

// File: design/instr_fetch.sv
`timescale 1ns/1ns

module instr_fetch (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic                       prog_we,
  input  logic [cpu_pkg::addr_w-1:0] prog_addr,
  input  logic [cpu_pkg::data_w-1:0] prog_data,
  ctrl_if.sink                       ctrl,
  input  logic                       zero,
  output logic [cpu_pkg::data_w-1:0] instr,
  output logic [cpu_pkg::addr_w-1:0] pc_next_seq,
  output logic                       halted
);
  import cpu_pkg::*;

  logic [data_w-1:0] imem [imem_depth];
  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] pc_branch;
  logic [addr_w-1:0] pc_next;
  logic [addr_w-1:0] jump_target;
  logic [data_w-1:0] imm;
  logic              branch_taken;
  logic              step;

  assign step        = run && !halted;
  assign instr       = imem[pc];  // async read
  assign imm         = imm_ext(instr);
  assign jump_target = instr[addr_w-1:0];
  assign pc_next_seq = pc + 1'b1;
  assign pc_branch   = pc_next_seq + imm[addr_w-1:0];

  assign branch_taken = (ctrl.beq && zero) || (ctrl.bne && !zero);

  always_comb begin
    if (ctrl.address_src) pc_next = jump_target;
    else if (branch_taken) pc_next = pc_branch;
    else pc_next = pc_next_seq;
  end

  // program load, only while the core is stopped
  always_ff @(posedge clk) begin
    if (prog_we && !run) imem[prog_addr] <= prog_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (step) begin
      pc <= pc_next;
      if (ctrl.address_src && jump_target == pc) halted <= 1'b1;  // self jump
    end
  end

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ns

module control_unit (
  input  cpu_pkg::opcode_t opcode,
  ctrl_if.decoder          ctrl
);
  import cpu_pkg::*;

  always_comb begin
    // defaults describe a no-op, each row turns on what it needs
    ctrl.reg_dst     = 1'b0;
    ctrl.alu_src     = 1'b0;
    ctrl.mem_to_reg  = 1'b0;
    ctrl.reg_write   = 1'b0;
    ctrl.mem_op      = mem_none;
    ctrl.alu_op      = alu_add;
    ctrl.beq         = 1'b0;
    ctrl.bne         = 1'b0;
    ctrl.address_src = 1'b0;

    case (opcode)
      op_add, op_sub, op_not, op_and, op_or, op_nand, op_nor, op_mov: begin
        ctrl.reg_dst   = 1'b1;  // r-type writes rd
        ctrl.reg_write = 1'b1;
        case (opcode)
          op_sub:  ctrl.alu_op = alu_sub;
          op_not:  ctrl.alu_op = alu_not;
          op_and:  ctrl.alu_op = alu_and;
          op_or:   ctrl.alu_op = alu_or;
          op_nand: ctrl.alu_op = alu_nand;
          op_nor:  ctrl.alu_op = alu_nor;
          op_mov:  ctrl.alu_op = alu_pass_a;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_addi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_add;
      end
      op_subi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sub;
      end
      op_li: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_pass_b;  // rt = imm
      end
      op_lw: begin
        ctrl.alu_src    = 1'b1;  // address rs + imm
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_op     = mem_read;
        ctrl.alu_op     = alu_add;
      end
      op_sw: begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_op  = mem_write;
        ctrl.alu_op  = alu_add;
      end
      op_beq: begin
        ctrl.beq    = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      op_bne: begin
        ctrl.bne    = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      op_jump: begin
        ctrl.address_src = 1'b1;
      end
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                           clk,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
  output logic [cpu_pkg::data_w-1:0]     rs_data,
  output logic [cpu_pkg::data_w-1:0]     rt_data,
  input  logic                           we,
  input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [cpu_pkg::data_w-1:0]     wr_data
);
  import cpu_pkg::*;

  logic [data_w-1:0] regs [num_regs];

  // r0 is hardwired to zero
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

  always_ff @(posedge clk) begin
    if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;  // lands at end of the cycle
    end
  end

endmodule

// File: design/alu.sv
`timescale 1ns/1ns

module alu (
  ctrl_if.sink                       ctrl,
  input  logic [cpu_pkg::data_w-1:0] instr,
  input  logic [cpu_pkg::data_w-1:0] rs_data,
  input  logic [cpu_pkg::data_w-1:0] rt_data,
  output logic [cpu_pkg::data_w-1:0] result,
  output logic                       zero
);
  import cpu_pkg::*;

  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;

  assign op_a = rs_data;
  assign op_b = ctrl.alu_src ? imm_ext(instr) : rt_data;
  assign zero = (rs_data == rt_data);  // branch compare

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_not:    result = ~op_a;
      alu_and:    result = op_a & op_b;
      alu_or:     result = op_a | op_b;
      alu_nand:   result = ~(op_a & op_b);
      alu_nor:    result = ~(op_a | op_b);
      alu_pass_a: result = op_a;  // mov
      alu_pass_b: result = op_b;  // li
      default:    result = '0;
    endcase
  end

endmodule

// File: design/mem_writeback.sv
`timescale 1ns/1ns

module mem_writeback (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           enable,
  ctrl_if.sink                           ctrl,
  input  logic [cpu_pkg::data_w-1:0]     alu_result,
  input  logic [cpu_pkg::data_w-1:0]     rt_data,
  input  logic [cpu_pkg::reg_addr_w-1:0] dest,
  output logic                           rf_we,
  output logic [cpu_pkg::data_w-1:0]     rf_wdata,
  output logic                           wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
  output logic [cpu_pkg::data_w-1:0]     wb_data,
  output logic                           st_valid,
  output logic [cpu_pkg::addr_w-1:0]     st_addr,
  output logic [cpu_pkg::data_w-1:0]     st_data
);
  import cpu_pkg::*;

  logic [data_w-1:0] dmem [dmem_depth];
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] load_word;
  logic              store;

  assign addr      = alu_result[addr_w-1:0];  // word address, low bits only
  assign load_word = (ctrl.mem_op == mem_read) ? dmem[addr] : '0;
  assign rf_wdata  = ctrl.mem_to_reg ? load_word : alu_result;
  assign rf_we     = enable && ctrl.reg_write && (dest != '0);
  assign store     = enable && (ctrl.mem_op == mem_write);

  always_ff @(posedge clk) begin
    if (store) dmem[addr] <= rt_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
      st_valid <= 1'b0;
    end else begin
      wb_valid <= rf_we;
      st_valid <= store;
    end
  end

  // event payload, qualified by the strobes
  always_ff @(posedge clk) begin
    wb_reg  <= dest;
    wb_data <= rf_wdata;
    st_addr <= addr;
    st_data <= rt_data;
  end

endmodule

// File: design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           run,
  input  logic                           prog_we,
  input  logic [cpu_pkg::addr_w-1:0]     prog_addr,
  input  logic [cpu_pkg::data_w-1:0]     prog_data,
  output logic                           wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
  output logic [cpu_pkg::data_w-1:0]     wb_data,
  output logic                           st_valid,
  output logic [cpu_pkg::addr_w-1:0]     st_addr,
  output logic [cpu_pkg::data_w-1:0]     st_data,
  output logic                           halted
);
  import cpu_pkg::*;

  logic [data_w-1:0]     instr;
  logic [data_w-1:0]     rs_data;
  logic [data_w-1:0]     rt_data;
  logic [data_w-1:0]     alu_result;
  logic [data_w-1:0]     rf_wdata;
  logic [reg_addr_w-1:0] dest;
  logic                  rf_we;
  logic                  zero;
  logic                  enable;

  ctrl_if ctrl ();

  assign enable = run && !halted;
  assign dest   = ctrl.reg_dst ? instr[rd_lsb +: reg_addr_w] : instr[rt_lsb +: reg_addr_w];

  instr_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .ctrl        (ctrl.sink),
    .zero        (zero),
    .instr       (instr),
    .pc_next_seq (),
    .halted      (halted)
  );

  control_unit u_ctrl (
    .opcode (opcode_t'(instr[op_lsb +: op_w])),
    .ctrl   (ctrl.decoder)
  );

  reg_file u_rf (
    .clk     (clk),
    .rs_addr (instr[rs_lsb +: reg_addr_w]),
    .rt_addr (instr[rt_lsb +: reg_addr_w]),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .we      (rf_we),
    .wr_addr (dest),
    .wr_data (rf_wdata)
  );

  alu u_alu (
    .ctrl    (ctrl.sink),
    .instr   (instr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .result  (alu_result),
    .zero    (zero)
  );

  mem_writeback u_mem (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .ctrl       (ctrl.sink),
    .alu_result (alu_result),
    .rt_data    (rt_data),
    .dest       (dest),
    .rf_we      (rf_we),
    .rf_wdata   (rf_wdata),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data)
  );

endmodule

// File: testbench/cpu_props.sv
`timescale 1ns/1ns

module cpu_props (
  input logic clk,
  input logic rst,
  input logic run,
  input logic wb_valid,
  input logic st_valid,
  input logic halted
);

  // a strobe reports the cycle before, so run was high one cycle earlier
  strobe_needs_run: assert property (
    @(posedge clk) disable iff (rst)
      !run && !$past(run) |-> !wb_valid && !st_valid
  ) else $error("retire or store strobe while the core was stopped");

  halted_sticky: assert property (
    @(posedge clk) $past(halted) && !$past(rst) |-> halted
  ) else $error("halted dropped without a reset");

  quiet_after_reset: assert property (
    @(posedge clk) $past(rst) |-> !wb_valid && !st_valid
  ) else $error("strobe in the cycle after reset");

endmodule

bind cpu_top cpu_props u_props (
  .clk      (clk),
  .rst      (rst),
  .run      (run),
  .wb_valid (wb_valid),
  .st_valid (st_valid),
  .halted   (halted)
);

// File: testbench/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
  import cpu_pkg::*;

  localparam int halt_timeout = 200;  // cycles
  localparam int drive_delay  = 5;    // ns after the rising edge

  logic                  clk;
  logic                  rst;
  logic                  run;
  logic                  prog_we;
  logic [addr_w-1:0]     prog_addr;
  logic [data_w-1:0]     prog_data;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_reg;
  logic [data_w-1:0]     wb_data;
  logic                  st_valid;
  logic [addr_w-1:0]     st_addr;
  logic [data_w-1:0]     st_data;
  logic                  halted;

  logic [addr_w-1:0]     prog_addr_q [$];
  logic [data_w-1:0]     prog_data_q [$];
  logic [reg_addr_w-1:0] exp_wb_reg [$];   // expected retires, in order
  logic [data_w-1:0]     exp_wb_data [$];
  logic [addr_w-1:0]     exp_st_addr [$];  // expected stores, in order
  logic [data_w-1:0]     exp_st_data [$];
  int                    wb_seen;
  int                    st_seen;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .st_valid  (st_valid),
    .st_addr   (st_addr),
    .st_data   (st_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [data_w-1:0] expected,
                             input logic [data_w-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic read_patterns();
    int                fd;
    int                n;
    string             line;
    logic [7:0]        kind;
    logic [data_w-1:0] a;
    logic [data_w-1:0] d;
    fd = $fopen("testbench/cpu_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/cpu_patterns.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%c %h %h", kind, a, d);
      if (n == 3) begin  // comment and blank lines fall through
        case (kind)
          "P": begin
            prog_addr_q.push_back(a[addr_w-1:0]);
            prog_data_q.push_back(d);
          end
          "W": begin
            exp_wb_reg.push_back(a[reg_addr_w-1:0]);
            exp_wb_data.push_back(d);
          end
          "S": begin
            exp_st_addr.push_back(a[addr_w-1:0]);
            exp_st_data.push_back(d);
          end
          default: begin
            $display("unknown line in the pattern file: %s", line);
            abort_run();
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  // the halt wait only makes sense if the program ends in a self jump
  function automatic bit has_self_jump();
    logic [data_w-1:0] word;
    for (int i = 0; i < prog_data_q.size(); i++) begin
      word = prog_data_q[i];
      if (opcode_t'(word[op_lsb +: op_w]) == op_jump && word[addr_w-1:0] == prog_addr_q[i])
        return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout, the core did not halt within %0d cycles", halt_timeout);
      abort_run();
    end
  endtask

  // reset with run still high, so a register write is pending at the reset edge
  task automatic reset_while_running();
    @(posedge clk);
    #drive_delay rst = 1'b1;
    repeat (2) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
    run = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // strobes are registered, so they are settled at the falling edge
  always @(negedge clk) begin
    if (!rst && wb_valid) begin
      if (wb_seen >= exp_wb_reg.size()) begin
        $display("unexpected register write to r%0d", wb_reg);
        abort_run();
      end else begin
        check_value($sformatf("write %0d reg", wb_seen),
                    data_w'(exp_wb_reg[wb_seen]), data_w'(wb_reg));
        check_value($sformatf("write %0d data", wb_seen), exp_wb_data[wb_seen], wb_data);
      end
      wb_seen++;
    end
    if (!rst && st_valid) begin
      if (st_seen >= exp_st_addr.size()) begin
        $display("unexpected store to address %h", st_addr);
        abort_run();
      end else begin
        check_value($sformatf("store %0d addr", st_seen),
                    data_w'(exp_st_addr[st_seen]), data_w'(st_addr));
        check_value($sformatf("store %0d data", st_seen), exp_st_data[st_seen], st_data);
      end
      st_seen++;
    end
  end

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    wb_seen   = 0;
    st_seen   = 0;

    read_patterns();
    if (!has_self_jump()) begin
      $display("the program in the pattern file has no self jump");
      abort_run();
    end

    repeat (2) @(posedge clk);
    #drive_delay rst = 1'b0;

    for (int i = 0; i < prog_addr_q.size(); i++) begin
      @(posedge clk);
      #drive_delay;
      prog_we   = 1'b1;
      prog_addr = prog_addr_q[i];
      prog_data = prog_data_q[i];
    end
    @(posedge clk);
    #drive_delay;
    prog_we = 1'b0;
    run     = 1'b1;

    wait_for_halt();
    repeat (4) @(negedge clk);  // window for a stray strobe after halt

    check_value("register write count", data_w'(exp_wb_reg.size()), data_w'(wb_seen));
    check_value("store count", data_w'(exp_st_addr.size()), data_w'(st_seen));

    reset_while_running();
    check_value("halted after reset", '0, data_w'(halted));

    $display("All checks passed");
    $finish;
  end

endmodule

// File: project.f
design/cpu_pkg.sv
design/ctrl_if.sv
design/instr_fetch.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/mem_writeback.sv
design/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// File: Makefile
TOP := cpu_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

obj_dir/V$(TOP): project.f $(wildcard design/*.sv testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/cpu_patterns.txt
# kind  addr-or-reg  data, all hex
# P program word, W expected register write, S expected store
P 00 A045  li   r1, 5
P 01 A0BD  li   r2, -3
P 02 0298  add  r3, r1, r2
P 03 22A0  sub  r4, r1, r2
P 04 4228  not  r5, r1
P 05 5AB0  and  r6, r5, r2
P 06 6338  or   r7, r1, r4
P 07 73D8  nand r3, r1, r7
P 08 8320  nor  r4, r1, r4
P 09 9E28  mov  r5, r7
P 0A 1F8A  addi r6, r7, 10
P 0B 3EBC  subi r2, r7, -4
P 0C A007  li   r0, 7
P 0D 0008  add  r1, r0, r0
P 0E CF83  sw   r6, 3(r7)
P 0F C13E  sw   r4, -2(r0)
P 10 BAC3  lw   r3, 3(r5)
P 11 B46D  lw   r1, -19(r2)
P 12 DBC2  beq  r5, r7, +2
P 13 A042  li   r1, 1
P 14 A082  li   r2, 2
P 15 E201  bne  r1, r0, +1
P 16 A0C3  li   r3, 3
P 17 D201  beq  r1, r0, +1
P 18 EBC1  bne  r5, r7, +1
P 19 A089  li   r2, 9
P 1A F01C  jump 28
P 1B A0C4  li   r3, 4
P 1C C085  sw   r2, 5(r0)
P 1D F01D  jump 29
W 1 0005
W 2 FFFD
W 3 0002
W 4 0008
W 5 FFFA
W 6 FFF8
W 7 000D
W 3 FFFA
W 4 FFF2
W 5 000D
W 6 0017
W 2 0011
W 1 0000
W 3 0017
W 1 FFF2
W 2 0009
S 10 0017
S FE FFF2
S 05 0009
